//--- include/mover_cfg.svh
// block mover configuration
`ifndef MOVER_CFG_SVH
`define MOVER_CFG_SVH

// ------------------------------
// DRAM read path
// ------------------------------

// address to data, in cycles; must be at least 2
`define MOVER_READ_LATENCY 4

// ------------------------------
// line buffer
// ------------------------------

`define MOVER_SECTION_DEPTH 32  // words per section, power of two
`define MOVER_FULL_SLACK 8      // free words left when full rises

// ------------------------------
// testbench
// ------------------------------

`define MOVER_TB_MARGIN 200     // extra cycles before timeout

`endif

//--- logic/dram_pkg.sv
// DRAM side types

package dram_pkg;

  // ------------------------------
  // addressing and data
  // ------------------------------

  typedef logic [11:0] dram_addr_t;  // word address, 4096 words
  typedef logic [15:0] dram_word_t;  // one data word

  // ------------------------------
  // block lengths
  // ------------------------------

  // requested words of a block, and words sent to the buffer
  typedef logic [4:0] block_len_t;

endpackage

//--- logic/lsab_pkg.sv
// line buffer side types

`include "mover_cfg.svh"

package lsab_pkg;

  // ------------------------------
  // buffer sections
  // ------------------------------

  typedef logic [1:0] section_t;  // one of four sections

  // fill level, one bit wider than the pointers so full fits
  typedef logic [$clog2(`MOVER_SECTION_DEPTH):0] lsab_level_t;

  // ------------------------------
  // fetch engine
  // ------------------------------

  typedef enum logic
  {
    fetch_idle,    // waiting for issue, or draining the pipeline
    fetch_stream   // putting out addresses
  } fetch_state_t;

endpackage

//--- logic/block_fetch.sv
// block fetch engine

`include "mover_cfg.svh"

module block_fetch
  import dram_pkg::*, lsab_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  dram_addr_t   start_address,
  input  block_len_t   count_req,
  input  section_t     section,
  input  logic         issue,
  input  logic [3:0]   section_full,
  output dram_addr_t   mem_address,
  output logic         mem_request,
  output logic         lsab_write,
  output section_t     lsab_section,
  output block_len_t   count_sent,
  output logic         busy
);

  typedef logic [$bits(block_len_t):0] words_t;  // wide enough for a rounded length of 32
  typedef logic [$clog2(`MOVER_READ_LATENCY + 2) - 1:0] delay_t;

  // ------------------------------
  // issue decode
  // ------------------------------

  fetch_state_t state;
  words_t       fetch_len;   // rounded out to even pairs
  words_t       words_left;  // addresses still to put out
  delay_t       open_cnt;    // cycles until the first write
  delay_t       close_cnt;   // cycles until the last write ends
  logic         take;
  logic         start_ok;
  logic         stream_end;

  assign take = issue && !busy;

  assign fetch_len = (words_t'(count_req) + words_t'(start_address[0]) + words_t'(1)) &
                     ~words_t'(1);

  // nothing to fetch, or the target section is already full
  assign start_ok = fetch_len != '0 && !section_full[section];

  assign stream_end = words_left == words_t'(1) || section_full[lsab_section];

  // ------------------------------
  // address stream
  // ------------------------------

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state        <= fetch_idle;
      mem_address  <= '0;
      mem_request  <= 1'b0;
      words_left   <= '0;
      lsab_section <= '0;
    end
    else
    begin
      case (state)
        fetch_idle:
        begin
          if (take)
          begin
            mem_address  <= start_address & ~dram_addr_t'(1);
            words_left   <= fetch_len;
            lsab_section <= section;
            if (start_ok)
            begin
              state       <= fetch_stream;
              mem_request <= 1'b1;
            end
          end
        end
        fetch_stream:
        begin
          mem_address <= mem_address + 1'b1;
          words_left  <= words_left - 1'b1;
          if (stream_end)  // last pair out, or back-pressure
          begin
            state       <= fetch_idle;
            mem_request <= 1'b0;
          end
        end
      endcase
    end
  end

  // ------------------------------
  // write window
  // ------------------------------

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      busy       <= 1'b0;
      lsab_write <= 1'b0;
      open_cnt   <= '0;
      close_cnt  <= '0;
      count_sent <= '0;
    end
    else if (take)
    begin
      busy       <= 1'b1;
      count_sent <= '0;
      open_cnt   <= delay_t'(`MOVER_READ_LATENCY) + delay_t'(start_address[0]);  // odd skips one
      close_cnt  <= start_ok ? '0 : delay_t'(`MOVER_READ_LATENCY);
    end
    else
    begin
      if (lsab_write)
        count_sent <= count_sent + 1'b1;

      if (state == fetch_stream && stream_end)
        close_cnt <= delay_t'(`MOVER_READ_LATENCY);  // last address just left
      else if (close_cnt != '0)
        close_cnt <= close_cnt - 1'b1;

      if (open_cnt != '0)
        open_cnt <= open_cnt - 1'b1;

      if (close_cnt == delay_t'(1))
      begin
        busy       <= 1'b0;
        lsab_write <= 1'b0;
        open_cnt   <= '0;  // a short block never opens
      end
      else if (open_cnt == delay_t'(1))
        lsab_write <= 1'b1;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  // a write window never opens into a full section
  a_no_write_into_full: assert property (@(posedge CLK) disable iff (!RST)
    $rose(lsab_write) |-> !section_full[lsab_section]);

  // addresses go out only while streaming
  a_request_in_stream: assert property (@(posedge CLK) disable iff (!RST)
    mem_request |-> state == fetch_stream);

endmodule

//--- logic/dram_read_port.sv
// DRAM read port

`include "mover_cfg.svh"

module dram_read_port
  import dram_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       mem_load,
  input  dram_addr_t mem_load_address,
  input  dram_word_t mem_load_data,
  input  dram_addr_t mem_address,
  input  logic       mem_request,
  output dram_word_t mem_data
);

  // ------------------------------
  // storage
  // ------------------------------

  dram_word_t mem_array [2 ** $bits(dram_addr_t)];

  always_ff @(posedge CLK)
  begin
    if (mem_load)
      mem_array[mem_load_address] <= mem_load_data;  // testbench fill
  end

  // ------------------------------
  // read pipeline
  // ------------------------------

  dram_word_t                       rd_pipe [`MOVER_READ_LATENCY];
  logic [`MOVER_READ_LATENCY - 1:0] rd_valid;  // one bit per stage

  // data stages, a new word enters on every cycle
  always_ff @(posedge CLK)
  begin
    rd_pipe[0] <= mem_array[mem_address];
    for (int i = 1; i < `MOVER_READ_LATENCY; i++)
    begin
      rd_pipe[i] <= rd_pipe[i - 1];
    end
  end

  // marks which stages hold a requested word
  always_ff @(posedge CLK)
  begin
    if (!RST)
      rd_valid <= '0;
    else
      rd_valid <= (rd_valid << 1) | (`MOVER_READ_LATENCY)'(mem_request);
  end

  // idle cycles show zero on the bus
  assign mem_data = rd_valid[`MOVER_READ_LATENCY - 1] ?
                    rd_pipe[`MOVER_READ_LATENCY - 1] : '0;

  // ------------------------------
  // checks
  // ------------------------------

  // the load port is for setup only, never during a transfer
  a_load_vs_read: assert property (@(posedge CLK) disable iff (!RST)
    mem_load |-> !mem_request && rd_valid == '0);

endmodule

//--- logic/lsab_sections.sv
// sectioned line buffer

`include "mover_cfg.svh"

module lsab_sections
  import dram_pkg::*, lsab_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       lsab_write,
  input  section_t   lsab_section,
  input  dram_word_t mem_data,
  input  logic       rd,
  input  section_t   rd_section,
  output dram_word_t rd_data,
  output logic       rd_empty,
  output logic [3:0] section_full
);

  // pointers wrap on their own since the depth is a power of two
  typedef logic [$clog2(`MOVER_SECTION_DEPTH) - 1:0] ptr_t;

  // ------------------------------
  // per section state
  // ------------------------------

  dram_word_t  sect_mem [4][`MOVER_SECTION_DEPTH];
  ptr_t        wr_ptr [4];
  ptr_t        rd_ptr [4];
  lsab_level_t level [4];

  logic [3:0]  do_wr;  // write strobe per section
  logic [3:0]  do_rd;  // pop strobe per section

  always_comb
  begin
    for (int s = 0; s < 4; s++)
    begin
      do_wr[s] = lsab_write && lsab_section == section_t'(s) &&
                 level[s] != lsab_level_t'(`MOVER_SECTION_DEPTH);
      do_rd[s] = rd && rd_section == section_t'(s) && level[s] != '0;

      // raised early so the words in flight still fit
      section_full[s] = level[s] >=
                        lsab_level_t'(`MOVER_SECTION_DEPTH - `MOVER_FULL_SLACK);
    end
  end

  // ------------------------------
  // storage
  // ------------------------------

  always_ff @(posedge CLK)
  begin
    if (do_wr[lsab_section])
      sect_mem[lsab_section][wr_ptr[lsab_section]] <= mem_data;
  end

  // ------------------------------
  // pointers and levels
  // ------------------------------

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int s = 0; s < 4; s++)
      begin
        wr_ptr[s] <= '0;
        rd_ptr[s] <= '0;
        level[s]  <= '0;
      end
    end
    else
    begin
      for (int s = 0; s < 4; s++)
      begin
        if (do_wr[s])
          wr_ptr[s] <= wr_ptr[s] + 1'b1;
        if (do_rd[s])
          rd_ptr[s] <= rd_ptr[s] + 1'b1;

        case ({do_wr[s], do_rd[s]})
          2'b10:   level[s] <= level[s] + 1'b1;
          2'b01:   level[s] <= level[s] - 1'b1;
          default: level[s] <= level[s];  // idle, or write and pop together
        endcase
      end
    end
  end

  // ------------------------------
  // read port
  // ------------------------------

  // head word shows before the pop
  assign rd_data  = sect_mem[rd_section][rd_ptr[rd_section]];
  assign rd_empty = level[rd_section] == '0;

  // ------------------------------
  // checks
  // ------------------------------

  // the slack must absorb every word still in the read pipeline
  a_no_overflow: assert property (@(posedge CLK) disable iff (!RST)
    lsab_write |-> level[lsab_section] != lsab_level_t'(`MOVER_SECTION_DEPTH));

  // the outside reader pops only what is there
  a_no_underflow: assert property (@(posedge CLK) disable iff (!RST)
    rd |-> level[rd_section] != '0);

endmodule

//--- logic/mover_top.sv
// DRAM to line buffer block mover

module mover_top
  import dram_pkg::*, lsab_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  // issue block
  input  dram_addr_t start_address,
  input  block_len_t count_req,
  input  section_t   section,
  input  logic       issue,
  // status
  output logic       busy,
  output block_len_t count_sent,
  // DRAM load
  input  logic       mem_load,
  input  dram_addr_t mem_load_address,
  input  dram_word_t mem_load_data,
  // buffer read
  input  section_t   rd_section,
  input  logic       rd,
  output dram_word_t rd_data,
  output logic       rd_empty,
  output logic [3:0] section_full
);

  // ------------------------------
  // internal paths
  // ------------------------------

  dram_addr_t mem_address;
  logic       mem_request;
  dram_word_t mem_data;
  logic       lsab_write;
  section_t   lsab_section;

  block_fetch u_fetch (
    .CLK           (CLK),
    .RST           (RST),
    .start_address (start_address),
    .count_req     (count_req),
    .section       (section),
    .issue         (issue),
    .section_full  (section_full),
    .mem_address   (mem_address),
    .mem_request   (mem_request),
    .lsab_write    (lsab_write),
    .lsab_section  (lsab_section),
    .count_sent    (count_sent),
    .busy          (busy)
  );

  dram_read_port u_dram (
    .CLK              (CLK),
    .RST              (RST),
    .mem_load         (mem_load),
    .mem_load_address (mem_load_address),
    .mem_load_data    (mem_load_data),
    .mem_address      (mem_address),
    .mem_request      (mem_request),
    .mem_data         (mem_data)
  );

  lsab_sections u_lsab (
    .CLK          (CLK),
    .RST          (RST),
    .lsab_write   (lsab_write),
    .lsab_section (lsab_section),
    .mem_data     (mem_data),
    .rd           (rd),
    .rd_section   (rd_section),
    .rd_data      (rd_data),
    .rd_empty     (rd_empty),
    .section_full (section_full)
  );

endmodule

//--- dv/mover_tb.sv
// block mover testbench

`include "mover_cfg.svh"

module mover_tb
  import dram_pkg::*, lsab_pkg::*;
();

  localparam int max_words = `MOVER_SECTION_DEPTH + 2;
  // load, transfer and a two-cycle-per-word drain for one block
  localparam int block_cycles = 4 * max_words + `MOVER_READ_LATENCY + 8;
  localparam int cycle_limit  = 14 * block_cycles + `MOVER_TB_MARGIN;

  logic       CLK = 1'b0;
  logic       RST;
  dram_addr_t start_address;
  block_len_t count_req;
  section_t   section;
  logic       issue;
  logic       busy;
  block_len_t count_sent;
  logic       mem_load;
  dram_addr_t mem_load_address;
  dram_word_t mem_load_data;
  section_t   rd_section;
  logic       rd;
  dram_word_t rd_data;
  logic       rd_empty;
  logic [3:0] section_full;

  dram_word_t  model [2 ** $bits(dram_addr_t)];  // expected DRAM contents
  dram_word_t  drained [$];                       // words popped by the last drain
  logic [31:0] lfsr_state;
  int          error_total = 0;
  int          check_total = 0;
  int          cycles = 0;

  mover_top dut (.*);

  always #5 CLK = ~CLK;

  // ------------------------------
  // timeout
  // ------------------------------

  always @(posedge CLK)
  begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_word(input string name, input dram_word_t exp, input dram_word_t act);
    check_total++;
    if (exp !== act)
    begin
      error_total++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input block_len_t exp, input block_len_t act);
    check_total++;
    if (exp !== act)
    begin
      error_total++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_total++;
    if (exp !== act)
    begin
      error_total++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_size(input string name, input int exp, input int act);
    check_total++;
    if (exp != act)
    begin
      error_total++;
      $display("mismatch %s: expected %0d words, actual %0d words", name, exp, act);
    end
  endtask

  // ------------------------------
  // stimulus helpers
  // ------------------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit
  task automatic next_random_word(output dram_word_t w);
    for (int b = 0; b < $bits(dram_word_t); b++)
    begin
      w[b]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  // covers the even word before an odd start and the pair rounding
  task automatic load_block(input dram_addr_t start, input int n);
    dram_addr_t addr;
    dram_word_t w;
    addr = start & ~dram_addr_t'(1);
    for (int i = 0; i < n + 3; i++)
    begin
      next_random_word(w);
      next_cycle();
      mem_load         = 1'b1;
      mem_load_address = addr;
      mem_load_data    = w;
      model[addr]      = w;
      addr             = addr + 1'b1;
    end
    next_cycle();
    mem_load = 1'b0;
  endtask

  task automatic issue_block(input dram_addr_t start, input block_len_t n, input section_t s);
    next_cycle();
    start_address = start;
    count_req     = n;
    section       = s;
    issue         = 1'b1;
    next_cycle();
    issue = 1'b0;
    check_flag("busy after issue", 1'b1, busy);
  endtask

  task automatic wait_idle();
    while (busy)
      next_cycle();
  endtask

  task automatic peek_empty(input section_t s, output logic empty);
    next_cycle();
    rd_section = s;
    @(negedge CLK);
    empty = rd_empty;
  endtask

  // head word is sampled, then popped on the next edge
  task automatic drain_section(input section_t s);
    logic done;
    done = 1'b0;
    drained.delete();
    next_cycle();
    rd_section = s;
    while (!done)
    begin
      @(negedge CLK);
      if (rd_empty || drained.size() > max_words)
        done = 1'b1;
      else
      begin
        drained.push_back(rd_data);
        next_cycle();
        rd = 1'b1;
        next_cycle();
        rd = 1'b0;
      end
    end
  endtask

  task automatic check_block(input string name, input dram_addr_t start,
                             input int first, input int n);
    for (int i = 0; i < n; i++)
    begin
      if (first + i >= drained.size())
      begin
        error_total++;
        $display("%s: section ran out of words at word %0d", name, i);
        return;
      end
      check_word(name, model[start + dram_addr_t'(i)], drained[first + i]);
    end
  endtask

  // ------------------------------
  // tests
  // ------------------------------

  task automatic test_reset_state();
    logic empty;
    check_flag("reset busy", 1'b0, busy);
    check_count("reset count_sent", '0, count_sent);
    for (int s = 0; s < 4; s++)
    begin
      check_flag("reset full", 1'b0, section_full[s]);
      peek_empty(section_t'(s), empty);
      check_flag("reset empty", 1'b1, empty);
    end
  endtask

  task automatic test_even_block();
    load_block(12'h040, 16);
    issue_block(12'h040, 5'd16, 2'd0);
    wait_idle();
    check_count("even count_sent", 5'd16, count_sent);
    drain_section(2'd0);
    check_size("even words", 16, drained.size());
    check_block("even data", 12'h040, 0, 16);
  endtask

  task automatic test_odd_blocks();
    dram_addr_t starts [3] = '{12'h101, 12'h200, 12'h305};
    block_len_t counts [3] = '{5'd7, 5'd9, 5'd10};
    int         sent;
    for (int c = 0; c < 3; c++)
    begin
      load_block(starts[c], int'(counts[c]));
      issue_block(starts[c], counts[c], 2'd1);
      wait_idle();
      sent = int'(count_sent);
      check_total++;
      if (sent < int'(counts[c]) || sent > int'(counts[c]) + 2)
      begin
        error_total++;
        $display("mismatch odd count_sent: expected %0d to %0d, actual %0d",
                 counts[c], int'(counts[c]) + 2, sent);
      end
      drain_section(2'd1);
      check_size("odd words", sent, drained.size());
      check_block("odd data", starts[c], 0, int'(counts[c]));  // pollution ignored
    end
  endtask

  task automatic test_section_routing();
    dram_addr_t start;
    block_len_t n;
    logic       empty;
    for (int s = 0; s < 4; s++)
    begin
      start = 12'h400 + dram_addr_t'(64 * s);
      n     = block_len_t'(6 + 2 * s);
      load_block(start, int'(n));
      issue_block(start, n, section_t'(s));
      wait_idle();
      for (int o = 0; o < 4; o++)
      begin
        if (o != s)
        begin
          peek_empty(section_t'(o), empty);
          check_flag("routing other empty", 1'b1, empty);
        end
      end
      drain_section(section_t'(s));
      check_size("routing words", int'(n), drained.size());
      check_block("routing data", start, 0, int'(n));
    end
  endtask

  task automatic test_back_pressure();
    dram_addr_t starts [$];
    int         sents [$];
    dram_addr_t start;
    int         rounds;
    int         total;
    int         first;
    rounds = 0;
    while (!section_full[2] && rounds < 2)
    begin
      start = 12'h600 + dram_addr_t'(64 * rounds);
      load_block(start, 30);
      issue_block(start, 5'd30, 2'd2);
      wait_idle();
      starts.push_back(start);
      sents.push_back(int'(count_sent));
      rounds++;
    end
    check_flag("prefill full", 1'b1, section_full[2]);
    load_block(12'h700, 20);
    issue_block(12'h700, 5'd20, 2'd2);
    wait_idle();
    starts.push_back(12'h700);
    sents.push_back(int'(count_sent));
    total = 0;
    foreach (sents[b])
      total += sents[b];
    if (total > `MOVER_SECTION_DEPTH)
    begin
      error_total++;
      $display("back-pressure: %0d words sent into a %0d word section",
               total, `MOVER_SECTION_DEPTH);
    end
    drain_section(2'd2);
    check_size("back-pressure words", total, drained.size());
    first = 0;
    foreach (starts[b])
    begin
      check_block("back-pressure data", starts[b], first, sents[b]);
      first += sents[b];
    end
    check_flag("full after drain", 1'b0, section_full[2]);
  endtask

  task automatic test_issue_while_busy();
    logic empty;
    load_block(12'h800, 12);
    load_block(12'h900, 4);
    next_cycle();
    start_address = 12'h800;
    count_req     = 5'd12;
    section       = 2'd3;
    issue         = 1'b1;
    next_cycle();
    start_address = 12'h900;  // second pulse, busy is already high
    count_req     = 5'd4;
    section       = 2'd1;
    check_flag("busy at second issue", 1'b1, busy);
    next_cycle();
    issue = 1'b0;
    wait_idle();
    check_count("busy issue count_sent", 5'd12, count_sent);
    peek_empty(2'd1, empty);
    check_flag("ignored issue section empty", 1'b1, empty);
    drain_section(2'd3);
    check_size("busy issue words", 12, drained.size());
    check_block("busy issue data", 12'h800, 0, 12);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial
  begin
    RST              = 1'b0;
    start_address    = '0;
    count_req        = '0;
    section          = '0;
    issue            = 1'b0;
    mem_load         = 1'b0;
    mem_load_address = '0;
    mem_load_data    = '0;
    rd_section       = '0;
    rd               = 1'b0;
    lfsr_state       = 32'hc0fe;
    repeat (3) @(posedge CLK);
    #1;
    RST = 1'b1;

    test_reset_state();
    test_even_block();
    test_odd_blocks();
    test_section_routing();
    test_back_pressure();
    test_issue_while_busy();

    $display("checks %0d, errors %0d", check_total, error_total);
    if (error_total == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- all.f
+incdir+include
logic/dram_pkg.sv
logic/lsab_pkg.sv
logic/block_fetch.sv
logic/dram_read_port.sv
logic/lsab_sections.sv
logic/mover_top.sv
dv/mover_tb.sv

//--- Makefile
SOURCES = $(filter-out +%,$(shell cat all.f)) include/mover_cfg.svh

obj_dir/Vmover_tb: all.f $(SOURCES)
	verilator --binary -j 0 -f all.f --top-module mover_tb -Mdir obj_dir

.PHONY: run clean

run: obj_dir/Vmover_tb
	@out="$$(./obj_dir/Vmover_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
